/* sv48_mmu.f */
verilog/mmu_pkg.sv
verilog/page_table_walker.sv
verilog/tlb.sv
verilog/dcache_port_mux.sv
verilog/sv48_mmu_top.sv
verification/pt_memory_model.sv
verification/sv48_mmu_tb.sv

/* Makefile */
# verilator build and run for the sv48 mmu testbench
VERILATOR ?= verilator
TOP       ?= sv48_mmu_tb
FILELIST  ?= sv48_mmu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wall

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/sv48_mmu_tb.sv */
module sv48_mmu_tb
    import mmu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_latency = 3;
    localparam int walk_cycles = levels * (mem_latency + 2);      // worst case walk
    localparam int wait_limit  = 2 * walk_cycles + 8;            // one lookup that may queue
    localparam int num_rows    = 11;
    localparam int cycle_limit = (num_rows + 3) * walk_cycles + 200;
    localparam logic [63:0] root_addr = 64'h1000_0000;
    localparam logic [63:0] t2_addr   = 64'h1000_1000;
    localparam logic [63:0] t1_addr   = 64'h1000_2000;
    localparam logic [63:0] t0_addr   = 64'h1000_3000;
    localparam logic [63:0] load_addr = 64'h2000_0040;
    localparam logic [43:0] ppn_4k = 44'h0ABCDEF0123;
    localparam logic [43:0] ppn_2m = 44'h00045678200;  // ppn0 zero
    localparam logic [43:0] ppn_1g = 44'h00000C40000;  // ppn1, ppn0 zero
    localparam logic [43:0] ppn_bad = 44'h00000012345; // 2M leaf with ppn0 not zero
    localparam logic [43:0] ppn_i  = 44'h00011112222;
    localparam logic [43:0] ppn_d  = 44'h00033334444;

    typedef struct packed {
        logic         port;       // 0 instruction, 1 data
        logic [63:0]  vaddr;
        logic         flush;
        logic         exp_hit;    // set for a one-cycle hit, clear when it must walk
        logic [63:0]  exp_paddr;
        tlb_perm_bits exp_perms;
        logic         exp_fault;
    } row_t;

    logic clk = 1'b0;
    logic reset, flush;
    logic i_lookup_valid, d_lookup_valid;
    logic [63:0] i_lookup_vaddr, d_lookup_vaddr;
    logic i_busy, i_xlate_valid, i_xlate_fault, d_busy, d_xlate_valid, d_xlate_fault;
    logic [63:0] i_xlate_paddr, d_xlate_paddr;
    tlb_perm_bits i_xlate_perms, d_xlate_perms;
    logic core_req_valid, core_resp_valid, core_stall;
    logic [63:0] core_req_addr, core_resp_data;
    logic dcache_req_valid, dcache_resp_valid;
    logic [63:0] dcache_req_addr, dcache_resp_data;

    row_t rows [$];
    logic [15:0] lfsr_state = 16'd47;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count  = 0;

    always #20 clk = ~clk;  // 40 ns period

    sv48_mmu_top dut (.*, .root_pt_addr(root_addr));

    pt_memory_model #(.latency(mem_latency)) mem (
        .clk, .reset,
        .req_valid  (dcache_req_valid),
        .req_addr   (dcache_req_addr),
        .resp_valid (dcache_resp_valid),
        .resp_data  (dcache_resp_data)
    );

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
    function automatic logic [11:0] take_bits(input int n);
        logic [11:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            r = {r[10:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic pte_t pointer_entry(input logic [63:0] table_addr);
        pte_t p;
        p = '0;
        p.ptr.ppn   = table_addr[55:12];
        p.ptr.perms = 8'h01;  // valid with r/w/x clear
        return p;
    endfunction

    function automatic pte_t leaf_entry(input logic [43:0] ppn, input logic [7:0] perms);
        pte_t p;
        p = '0;
        p.leaf.ppn3  = 18'(ppn[43:27]);
        p.leaf.ppn2  = ppn[26:18];
        p.leaf.ppn1  = ppn[17:9];
        p.leaf.ppn0  = ppn[8:0];
        p.leaf.perms = perms;
        return p;
    endfunction

    function automatic logic [63:0] make_va(input logic [8:0] v3, input logic [8:0] v2,
                                            input logic [8:0] v1, input logic [8:0] v0,
                                            input logic [11:0] off);
        return {16'b0, v3, v2, v1, v0, off};
    endfunction

    task write_pte(input logic [63:0] base, input int idx, input pte_t p);
        mem.write_word(base + 64'(idx) * 8, p);
    endtask

    task add_row(input logic port, input logic [63:0] va, input logic fl, input logic hit,
                 input logic [63:0] pa, input logic [7:0] perms, input logic fault);
        row_t r;
        r.port = port;
        r.vaddr = va;
        r.flush = fl;
        r.exp_hit = hit;
        r.exp_paddr = pa;
        r.exp_perms = perms;
        r.exp_fault = fault;
        rows.push_back(r);
    endtask

    // one table lookup checked on the falling edge where outputs are settled
    task lookup_row(input row_t r, input int idx);
        logic got;
        int cycles;
        int dc_reqs;
        logic [63:0] pa;
        tlb_perm_bits pm;
        logic flt;
        got = 1'b0;
        cycles = 0;
        dc_reqs = 0;
        @(negedge clk);
        if (r.flush) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
        if (r.port) begin
            d_lookup_valid = 1'b1;
            d_lookup_vaddr = r.vaddr;
        end else begin
            i_lookup_valid = 1'b1;
            i_lookup_vaddr = r.vaddr;
        end
        while (!got && cycles < wait_limit) begin
            @(negedge clk);
            i_lookup_valid = 1'b0;
            d_lookup_valid = 1'b0;
            cycles++;
            if (dcache_req_valid) begin
                dc_reqs++;
                if (!core_stall) begin
                    $display("row %0d: core_stall low while the walker used the port", idx);
                    other_errors++;
                end
            end
            got = r.port ? d_xlate_valid : i_xlate_valid;
            pa  = r.port ? d_xlate_paddr : i_xlate_paddr;
            pm  = r.port ? d_xlate_perms : i_xlate_perms;
            flt = r.port ? d_xlate_fault : i_xlate_fault;
            if (r.exp_hit && cycles == 1 && (r.port ? d_busy : i_busy)) begin
                $display("row %0d: busy went high on an expected hit", idx);
                other_errors++;
            end
        end
        if (!got) begin
            $display("row %0d: no translation response within %0d cycles", idx, wait_limit);
            other_errors++;
        end else begin
            if (r.exp_hit && (cycles != 1 || dc_reqs != 0)) begin
                $display("row %0d: hit took %0d cycles with %0d cache requests",
                         idx, cycles, dc_reqs);
                other_errors++;
            end
            if (!r.exp_hit && dc_reqs == 0) begin
                $display("row %0d: expected a table walk but saw no cache request", idx);
                other_errors++;
            end
            if (flt != r.exp_fault) begin
                $display("ERR xlate_fault row %0d: got %h expected %h", idx, flt, r.exp_fault);
                value_errors++;
            end
            if (!r.exp_fault && pa != r.exp_paddr) begin
                $display("ERR xlate_paddr row %0d: got %h expected %h", idx, pa, r.exp_paddr);
                value_errors++;
            end
            if (!r.exp_fault && pm != r.exp_perms) begin
                $display("ERR xlate_perms row %0d: got %h expected %h", idx, pm, r.exp_perms);
                value_errors++;
            end
        end
    endtask

    // both ports miss together and port 0 is served first
    task dual_miss(input logic [63:0] va_i, input logic [63:0] pa_i, input tlb_perm_bits pm_i,
                   input logic [63:0] va_d, input logic [63:0] pa_d, input tlb_perm_bits pm_d);
        int cycles;
        int i_at;
        int d_at;
        cycles = 0;
        i_at = 0;
        d_at = 0;
        @(negedge clk);
        i_lookup_valid = 1'b1;
        i_lookup_vaddr = va_i;
        d_lookup_valid = 1'b1;
        d_lookup_vaddr = va_d;
        while ((i_at == 0 || d_at == 0) && cycles < wait_limit) begin
            @(negedge clk);
            i_lookup_valid = 1'b0;
            d_lookup_valid = 1'b0;
            cycles++;
            if (i_xlate_valid) begin
                i_at = cycles;
                if (i_xlate_paddr != pa_i) begin
                    $display("ERR i_xlate_paddr dual: got %h expected %h", i_xlate_paddr, pa_i);
                    value_errors++;
                end
                if (i_xlate_perms != pm_i) begin
                    $display("ERR i_xlate_perms dual: got %h expected %h", i_xlate_perms, pm_i);
                    value_errors++;
                end
                if (i_xlate_fault) begin
                    $display("ERR i_xlate_fault dual: got %h expected %h", i_xlate_fault, 1'b0);
                    value_errors++;
                end
            end
            if (d_xlate_valid) begin
                d_at = cycles;
                if (d_xlate_paddr != pa_d) begin
                    $display("ERR d_xlate_paddr dual: got %h expected %h", d_xlate_paddr, pa_d);
                    value_errors++;
                end
                if (d_xlate_perms != pm_d) begin
                    $display("ERR d_xlate_perms dual: got %h expected %h", d_xlate_perms, pm_d);
                    value_errors++;
                end
                if (d_xlate_fault) begin
                    $display("ERR d_xlate_fault dual: got %h expected %h", d_xlate_fault, 1'b0);
                    value_errors++;
                end
            end
        end
        if (i_at == 0 || d_at == 0 || i_at >= d_at) begin
            $display("dual miss: responses missing or out of order (i at %0d, d at %0d)",
                     i_at, d_at);
            other_errors++;
        end
    endtask

    // plain load through the mux while no walk runs
    task core_load(input logic [63:0] addr, input logic [63:0] exp_data);
        int cycles;
        logic got;
        cycles = 0;
        got = 1'b0;
        @(negedge clk);
        if (core_stall) begin
            $display("core_stall high with no walk active");
            other_errors++;
        end
        core_req_valid = 1'b1;
        core_req_addr  = addr;
        while (!got && cycles < wait_limit) begin
            @(negedge clk);
            if (cycles == 0) begin
                if (!dcache_req_valid) begin
                    $display("core load did not reach the data cache port");
                    other_errors++;
                end else if (dcache_req_addr != addr) begin
                    $display("ERR dcache_req_addr: got %h expected %h", dcache_req_addr, addr);
                    value_errors++;
                end
            end
            core_req_valid = 1'b0;
            cycles++;
            got = core_resp_valid;
        end
        if (!got) begin
            $display("core load got no response");
            other_errors++;
        end else if (core_resp_data != exp_data) begin
            $display("ERR core_resp_data: got %h expected %h", core_resp_data, exp_data);
            value_errors++;
        end
    endtask

    initial begin
        logic [11:0] off;
        logic [63:0] va_a, va_b, va_c, va_d, va_e, va_f, va_g;
        reset = 1'b1;
        flush = 1'b0;
        i_lookup_valid = 1'b0;
        i_lookup_vaddr = '0;
        d_lookup_valid = 1'b0;
        d_lookup_vaddr = '0;
        core_req_valid = 1'b0;
        core_req_addr  = '0;

        // walk chain runs root[1] to t2, t2[2] to t1 and t1[3] to t0
        write_pte(root_addr, 1, pointer_entry(t2_addr));
        write_pte(t2_addr, 2, pointer_entry(t1_addr));
        write_pte(t2_addr, 6, leaf_entry(ppn_1g, 8'hcb));
        write_pte(t1_addr, 3, pointer_entry(t0_addr));
        write_pte(t1_addr, 5, leaf_entry(ppn_2m, 8'h47));
        write_pte(t1_addr, 10, leaf_entry(ppn_bad, 8'h03));
        write_pte(t0_addr, 4, leaf_entry(ppn_4k, 8'h4b));
        write_pte(t0_addr, 7, '0);                         // invalid
        write_pte(t0_addr, 8, leaf_entry(ppn_4k, 8'h05));  // write without read
        write_pte(t0_addr, 9, pointer_entry(64'h1000_4000));   // pointer at level 0
        write_pte(t0_addr, 12, leaf_entry(ppn_i, 8'h0b));
        write_pte(t0_addr, 13, leaf_entry(ppn_d, 8'h07));
        mem.write_word(load_addr, 64'hfeed_beef_0bad_cafe);

        off = take_bits(12);
        va_a = make_va(1, 2, 3, 4, off);
        add_row(0, va_a, 0, 0, {8'b0, ppn_4k, off}, 8'h4b, 0);
        off = take_bits(12);
        add_row(0, {va_a[63:12], off}, 0, 1, {8'b0, ppn_4k, off}, 8'h4b, 0);
        add_row(0, {va_a[63:12], off}, 1, 0, {8'b0, ppn_4k, off}, 8'h4b, 0);
        off = take_bits(12);
        va_b = make_va(1, 2, 5, 9'h1a3, off);
        add_row(1, va_b, 0, 0, {8'b0, ppn_2m[43:9], 9'h1a3, off}, 8'h47, 0);
        off = take_bits(12);
        va_c = make_va(1, 6, 9'h055, 9'h0f1, off);
        add_row(0, va_c, 0, 0, {8'b0, ppn_1g[43:18], 9'h055, 9'h0f1, off}, 8'hcb, 0);
        off = take_bits(12);
        va_d = make_va(1, 2, 3, 7, off);
        add_row(1, va_d, 0, 0, '0, 8'h00, 1);
        add_row(1, va_d, 0, 0, '0, 8'h00, 1);  // not cached so it walks again
        va_e = make_va(1, 2, 3, 8, off);
        add_row(1, va_e, 0, 0, '0, 8'h00, 1);
        va_f = make_va(1, 2, 3, 9, off);
        add_row(0, va_f, 0, 0, '0, 8'h00, 1);
        va_g = make_va(1, 2, 10, 9'h011, off);
        add_row(1, va_g, 0, 0, '0, 8'h00, 1);
        add_row(1, {va_c[63:12], off}, 0, 0, {8'b0, ppn_1g[43:18], 9'h055, 9'h0f1, off},
                8'hcb, 0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            lookup_row(rows[i], i);
        end
        off = take_bits(12);
        dual_miss(make_va(1, 2, 3, 12, off), {8'b0, ppn_i, off}, 8'h0b,
                  make_va(1, 2, 3, 13, off), {8'b0, ppn_d, off}, 8'h07);
        core_load(load_addr, 64'hfeed_beef_0bad_cafe);

        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verification/pt_memory_model.sv */
module pt_memory_model #(
    parameter int latency = 3             // cycles from request to response, at least 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  logic [63:0] req_addr,
    output logic        resp_valid,
    output logic [63:0] resp_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [63:0] words [logic [63:0]];    // sparse backing store, keyed by byte address
    logic [latency-1:0] vld_pipe;
    logic [63:0]        data_pipe [latency];

    // words never written read back as a pattern of the full address
    function automatic logic [63:0] read_word(input logic [63:0] addr);
        logic [63:0] w;
        if (words.exists(addr))
            w = words[addr];
        else
            w = addr ^ {addr[31:0], addr[63:32]} ^ 64'ha5a5_5a5a_c3c3_3c3c;
        return w;
    endfunction

    // testbench side, used before the run to lay out the tables
    task write_word(input logic [63:0] addr, input logic [63:0] data);
        words[addr] = data;
    endtask

    // fixed latency pipe, data captured at request time
    always_ff @(posedge clk) begin
        if (reset)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[latency-2:0], req_valid};
        data_pipe[0] <= read_word(req_addr);
        for (int i = 1; i < latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign resp_valid = vld_pipe[latency-1];
    assign resp_data  = data_pipe[latency-1];

endmodule

/* verilog/sv48_mmu_top.sv */
module sv48_mmu_top
    import mmu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    input  logic [63:0]  root_pt_addr,

    // instruction side
    input  logic         i_lookup_valid,
    input  logic [63:0]  i_lookup_vaddr,
    output logic         i_busy,
    output logic         i_xlate_valid,
    output logic [63:0]  i_xlate_paddr,
    output tlb_perm_bits i_xlate_perms,
    output logic         i_xlate_fault,

    // data side
    input  logic         d_lookup_valid,
    input  logic [63:0]  d_lookup_vaddr,
    output logic         d_busy,
    output logic         d_xlate_valid,
    output logic [63:0]  d_xlate_paddr,
    output tlb_perm_bits d_xlate_perms,
    output logic         d_xlate_fault,

    // core loads through the shared port
    input  logic         core_req_valid,
    input  logic [63:0]  core_req_addr,
    output logic         core_resp_valid,
    output logic [63:0]  core_resp_data,
    output logic         core_stall,

    // data cache
    output logic         dcache_req_valid,
    output logic [63:0]  dcache_req_addr,
    input  logic         dcache_resp_valid,
    input  logic [63:0]  dcache_resp_data
);

    logic         i_walk_req_valid, d_walk_req_valid;
    logic [63:0]  i_walk_req_vaddr, d_walk_req_vaddr;
    logic         walk_resp0_valid, walk_resp1_valid;
    logic [63:0]  walk_resp_paddr;
    tlb_perm_bits walk_resp_perms;
    logic         walk_resp_fault;
    logic         use_dcache;
    logic         walk_dc_req_valid, walk_dc_resp_valid;
    logic [63:0]  walk_dc_req_addr, walk_dc_resp_data;

    tlb itlb (
        .clk, .reset, .flush,
        .lookup_valid    (i_lookup_valid),
        .lookup_vaddr    (i_lookup_vaddr),
        .busy            (i_busy),
        .xlate_valid     (i_xlate_valid),
        .xlate_paddr     (i_xlate_paddr),
        .xlate_perms     (i_xlate_perms),
        .xlate_fault     (i_xlate_fault),
        .walk_req_valid  (i_walk_req_valid),
        .walk_req_vaddr  (i_walk_req_vaddr),
        .walk_resp_valid (walk_resp0_valid),  // port 0 of the walker
        .walk_resp_paddr (walk_resp_paddr),
        .walk_resp_perms (walk_resp_perms),
        .walk_resp_fault (walk_resp_fault)
    );

    tlb dtlb (
        .clk, .reset, .flush,
        .lookup_valid    (d_lookup_valid),
        .lookup_vaddr    (d_lookup_vaddr),
        .busy            (d_busy),
        .xlate_valid     (d_xlate_valid),
        .xlate_paddr     (d_xlate_paddr),
        .xlate_perms     (d_xlate_perms),
        .xlate_fault     (d_xlate_fault),
        .walk_req_valid  (d_walk_req_valid),
        .walk_req_vaddr  (d_walk_req_vaddr),
        .walk_resp_valid (walk_resp1_valid),
        .walk_resp_paddr (walk_resp_paddr),
        .walk_resp_perms (walk_resp_perms),
        .walk_resp_fault (walk_resp_fault)
    );

    page_table_walker ptw (
        .clk, .reset,
        .req0_vaddr        (i_walk_req_vaddr),
        .req0_valid        (i_walk_req_valid),
        .req1_vaddr        (d_walk_req_vaddr),
        .req1_valid        (d_walk_req_valid),
        .resp_paddr        (walk_resp_paddr),
        .resp_perms        (walk_resp_perms),
        .resp_fault        (walk_resp_fault),
        .resp0_valid       (walk_resp0_valid),
        .resp1_valid       (walk_resp1_valid),
        .use_dcache        (use_dcache),
        .dcache_req_valid  (walk_dc_req_valid),
        .dcache_req_addr   (walk_dc_req_addr),
        .dcache_resp_valid (walk_dc_resp_valid),
        .dcache_resp_data  (walk_dc_resp_data),
        .root_pt_addr      (root_pt_addr)
    );

    dcache_port_mux dc_mux (
        .clk, .reset,
        .use_dcache        (use_dcache),
        .walk_req_valid    (walk_dc_req_valid),
        .walk_req_addr     (walk_dc_req_addr),
        .walk_resp_valid   (walk_dc_resp_valid),
        .walk_resp_data    (walk_dc_resp_data),
        .core_req_valid    (core_req_valid),
        .core_req_addr     (core_req_addr),
        .core_resp_valid   (core_resp_valid),
        .core_resp_data    (core_resp_data),
        .core_stall        (core_stall),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_addr   (dcache_req_addr),
        .dcache_resp_valid (dcache_resp_valid),
        .dcache_resp_data  (dcache_resp_data)
    );

endmodule

/* verilog/dcache_port_mux.sv */
module dcache_port_mux (
    input  logic         clk,
    input  logic         reset,

    // walker side
    input  logic         use_dcache,       // walker owns the port while high
    input  logic         walk_req_valid,
    input  logic [63:0]  walk_req_addr,
    output logic         walk_resp_valid,
    output logic [63:0]  walk_resp_data,

    // core load side
    input  logic         core_req_valid,
    input  logic [63:0]  core_req_addr,
    output logic         core_resp_valid,
    output logic [63:0]  core_resp_data,
    output logic         core_stall,       // core request dropped, retry later

    // to the data cache
    output logic         dcache_req_valid,
    output logic [63:0]  dcache_req_addr,
    input  logic         dcache_resp_valid,
    input  logic [63:0]  dcache_resp_data
);

    logic owner_walk;  // owner of the last accepted request

    // request steering, walker has the port whenever it asks
    assign core_stall       = use_dcache;
    assign dcache_req_valid = use_dcache ? walk_req_valid : core_req_valid;
    assign dcache_req_addr  = use_dcache ? walk_req_addr  : core_req_addr;

    always_ff @(posedge clk) begin
        if (reset)
            owner_walk <= 1'b0;
        else if (dcache_req_valid)
            owner_walk <= use_dcache;
    end

    // response goes to whoever issued it, even if ownership moved since
    assign walk_resp_valid = dcache_resp_valid && owner_walk;
    assign core_resp_valid = dcache_resp_valid && !owner_walk;
    assign walk_resp_data  = dcache_resp_data;
    assign core_resp_data  = dcache_resp_data;

endmodule

/* verilog/tlb.sv */
module tlb
    import mmu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,          // drops every entry

    // core side
    input  logic         lookup_valid,   // only while busy is low
    input  logic [63:0]  lookup_vaddr,
    output logic         busy,
    output logic         xlate_valid,
    output logic [63:0]  xlate_paddr,
    output tlb_perm_bits xlate_perms,
    output logic         xlate_fault,

    // walker side
    output logic         walk_req_valid, // held until the walker answers
    output logic [63:0]  walk_req_vaddr,
    input  logic         walk_resp_valid,
    input  logic [63:0]  walk_resp_paddr,
    input  tlb_perm_bits walk_resp_perms,
    input  logic         walk_resp_fault
);

    // entry storage, superpages land here as the 4 KiB page that was touched
    logic [vaddr_bits-page_offset_bits-1:0] tag_q  [tlb_entries];
    logic [63-page_offset_bits:0]           ppn_q  [tlb_entries];
    tlb_perm_bits                           perm_q [tlb_entries];
    logic [tlb_entries-1:0]                 valid_q;

    logic [tlb_idx_bits-1:0]                rr_ptr;    // next victim
    logic [tlb_idx_bits-1:0]                hit_idx;
    logic                                   hit;
    logic                                   pending;   // miss outstanding at the walker
    logic [vaddr_bits-page_offset_bits-1:0] lookup_vpn;
    logic [vaddr_bits-page_offset_bits-1:0] pend_vpn;

    assign lookup_vpn = lookup_vaddr[vaddr_bits-1:page_offset_bits];
    assign pend_vpn   = walk_req_vaddr[vaddr_bits-1:page_offset_bits];

    // fully associative compare
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (valid_q[i] && tag_q[i] == lookup_vpn) begin
                hit     = 1'b1;
                hit_idx = tlb_idx_bits'(i);
            end
        end
    end

    // a miss is both the core's busy and the walker's request
    assign busy           = pending;
    assign walk_req_valid = pending;

    // control
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= '0;
            rr_ptr      <= '0;
            pending     <= 1'b0;
            xlate_valid <= 1'b0;
        end else begin
            xlate_valid <= 1'b0;
            if (pending) begin
                if (walk_resp_valid) begin
                    pending     <= 1'b0;
                    xlate_valid <= 1'b1;  // one cycle after the walker pulse
                    if (!walk_resp_fault) begin  // faults are never cached
                        valid_q[rr_ptr] <= 1'b1;
                        rr_ptr          <= rr_ptr + 1'b1;
                    end
                end
            end else if (lookup_valid) begin
                if (hit)
                    xlate_valid <= 1'b1;
                else
                    pending <= 1'b1;
            end
            if (flush)
                valid_q <= '0;  // wins over a refill in the same cycle
        end
    end

    // entries and response payload
    always_ff @(posedge clk) begin
        if (!pending && lookup_valid) begin
            walk_req_vaddr <= lookup_vaddr;  // only read on a miss
            xlate_paddr    <= {ppn_q[hit_idx], lookup_vaddr[page_offset_bits-1:0]};
            xlate_perms    <= perm_q[hit_idx];
            xlate_fault    <= 1'b0;
        end
        if (pending && walk_resp_valid) begin
            tag_q[rr_ptr]  <= pend_vpn;
            ppn_q[rr_ptr]  <= walk_resp_paddr[63:page_offset_bits];
            perm_q[rr_ptr] <= walk_resp_perms;
            xlate_paddr    <= {walk_resp_paddr[63:page_offset_bits],
                               walk_req_vaddr[page_offset_bits-1:0]};
            xlate_perms    <= walk_resp_perms;
            xlate_fault    <= walk_resp_fault;
        end
    end

endmodule

/* verilog/page_table_walker.sv */
module page_table_walker
    import mmu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // two request ports, 0 is the instruction tlb
    input  logic [63:0]  req0_vaddr,
    input  logic         req0_valid,
    input  logic [63:0]  req1_vaddr,
    input  logic         req1_valid,

    // shared response, valid per port
    output logic [63:0]  resp_paddr,     // page aligned, offset added by the tlb
    output tlb_perm_bits resp_perms,
    output logic         resp_fault,
    output logic         resp0_valid,
    output logic         resp1_valid,

    // data cache side, physical mode while walking
    output logic         use_dcache,
    output logic         dcache_req_valid,
    output logic [63:0]  dcache_req_addr,
    input  logic         dcache_resp_valid,
    input  logic [63:0]  dcache_resp_data,

    input  logic [63:0]  root_pt_addr
);

    logic [1:0]                state;
    logic                      cur_port;      // 0 serving port 0, 1 serving port 1
    logic                      issue;         // first cycle of a level's fetch
    logic [63:0]               xlate_vaddr;   // address being translated
    logic [63:0]               cur_pt_addr;   // table base at the current level
    logic [$clog2(levels)-1:0] cur_level;     // levels-1 at root, 0 at the last level
    pte_t                      resp_pte;      // entry coming back from the cache
    pte_t                      leaf_pte;      // kept for address assembly in done
    logic                      fault_r;

    logic [vpn_bits-1:0] vaddr_vpn [levels];
    logic [vpn_bits-1:0] cur_vpn;
    logic [vpn_bits-1:0] final_ppn [levels-1];
    logic                is_pointer;
    logic                bad_entry;
    logic                misaligned;

    // lower ppn fields of the leaf view, index 0 is ppn0
    function automatic logic [vpn_bits-1:0] leaf_ppn(input pte_t pte, input int idx);
        logic [vpn_bits-1:0] f;
        case (idx)
            0:       f = pte.leaf.ppn0;
            1:       f = pte.leaf.ppn1;
            default: f = pte.leaf.ppn2;
        endcase
        return f;
    endfunction

    always_comb begin
        for (int i = 0; i < levels; i++) begin
            vaddr_vpn[i] = xlate_vaddr[page_offset_bits + i * vpn_bits +: vpn_bits];
        end
    end
    assign cur_vpn = vaddr_vpn[cur_level];

    // decode of the returning entry
    assign resp_pte   = dcache_resp_data;
    assign is_pointer = !(resp_pte.leaf.perms.read || resp_pte.leaf.perms.write ||
                          resp_pte.leaf.perms.exec);
    assign bad_entry  = !resp_pte.leaf.perms.valid ||
                        (resp_pte.leaf.perms.write && !resp_pte.leaf.perms.read);

    // a superpage leaf must have zeros in every ppn field below its level
    always_comb begin
        misaligned = 1'b0;
        for (int i = 0; i < levels - 1; i++) begin
            if (i < int'(cur_level) && leaf_ppn(resp_pte, i) != '0)
                misaligned = 1'b1;
        end
    end

    // cache port: table base plus vpn*8
    assign use_dcache       = (state != walk_idle);
    assign dcache_req_valid = (state == walk_fetching) && issue;
    assign dcache_req_addr  = {cur_pt_addr[63:page_offset_bits], cur_vpn,
                               {pte_bytes_log2{1'b0}}};

    // superpage levels keep the vpn bits as part of the offset
    always_comb begin
        for (int i = 0; i < levels - 1; i++) begin
            final_ppn[i] = (i < int'(cur_level)) ? vaddr_vpn[i] : leaf_ppn(leaf_pte, i);
        end
    end
    assign resp_paddr  = 64'({leaf_pte.leaf.ppn3, final_ppn[2], final_ppn[1], final_ppn[0],
                              {page_offset_bits{1'b0}}});
    assign resp_perms  = leaf_pte.leaf.perms;
    assign resp_fault  = fault_r;
    assign resp0_valid = (state == walk_done) && !cur_port;
    assign resp1_valid = (state == walk_done) && cur_port;

    // fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= walk_idle;
            issue    <= 1'b0;
            cur_port <= 1'b0;
        end else begin
            issue <= 1'b0;  // one-cycle strobe
            case (state)
                walk_idle: begin
                    if (req0_valid || req1_valid) begin
                        state    <= walk_fetching;
                        issue    <= 1'b1;
                        cur_port <= !req0_valid;  // port 0 wins ties
                    end
                end
                walk_fetching: begin
                    if (dcache_resp_valid) begin
                        if (bad_entry || !is_pointer || cur_level == '0)
                            state <= walk_done;   // leaf, fault, or fell off the table
                        else
                            issue <= 1'b1;        // next level
                    end
                end
                walk_done: state <= walk_idle;
                default:   state <= walk_idle;
            endcase
        end
    end

    // walk payload
    always_ff @(posedge clk) begin
        if (state == walk_idle && (req0_valid || req1_valid)) begin
            xlate_vaddr <= req0_valid ? req0_vaddr : req1_vaddr;
            cur_level   <= ($clog2(levels))'(levels - 1);
            cur_pt_addr <= root_pt_addr;
        end
        if (state == walk_fetching && dcache_resp_valid) begin
            leaf_pte <= resp_pte;
            fault_r  <= bad_entry || (is_pointer && cur_level == '0) ||
                        (!is_pointer && misaligned);
            if (!bad_entry && is_pointer && cur_level != '0) begin
                cur_pt_addr <= {8'b0, resp_pte.ptr.ppn, {page_offset_bits{1'b0}}};
                cur_level   <= cur_level - 1'b1;
            end
        end
    end

endmodule

/* verilog/mmu_pkg.sv */
package mmu_pkg;

    // sv48 geometry
    localparam int levels           = 4;    // page table levels, root is levels-1
    localparam int page_offset_bits = 12;   // 4 KiB base page
    localparam int vpn_bits         = 9;    // vpn slice per level
    localparam int pte_bytes_log2   = 3;    // 8-byte entries
    localparam int vaddr_bits       = page_offset_bits + levels * vpn_bits;  // 48

    // tlb geometry
    localparam int tlb_entries  = 4;
    localparam int tlb_idx_bits = $clog2(tlb_entries);

    // walker fsm encoding
    localparam logic [1:0] walk_idle     = 2'd0;
    localparam logic [1:0] walk_fetching = 2'd1;  // one level per cache round trip
    localparam logic [1:0] walk_done     = 2'd2;

    // low byte of a pte, DAGUXWRV from msb to lsb
    typedef struct packed {
        logic dirty;     // not updated by this design
        logic accessed;  // not updated either
        logic glob;
        logic usermode;
        logic exec;
        logic write;
        logic read;
        logic valid;
    } tlb_perm_bits;

    // same 64-bit word, read as a leaf or as a pointer depending on r/w/x
    typedef union packed {
        struct packed {
            logic [8:0]   reserved;
            logic [17:0]  ppn3;     // always taken from the pte
            logic [8:0]   ppn2;     // these three may be replaced by vpn bits on superpages
            logic [8:0]   ppn1;
            logic [8:0]   ppn0;
            logic [1:0]   rsw;
            tlb_perm_bits perms;
        } leaf;
        struct packed {
            logic [9:0]   reserved;
            logic [43:0]  ppn;      // next table, page aligned
            logic [1:0]   rsw;
            tlb_perm_bits perms;    // r/w/x all zero for a pointer
        } ptr;
    } pte_t;

endpackage
